// File: include/decode_params.svh
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// datapath and instruction word width
`define XLEN 32

// architectural register index
`define REG_IDX_W 5

// reorder buffer tag, 16 entries
`define ROB_TAG_W 4

// internal op code width, 37 ops fit in 6 bits
`define OP_W 6

// RV32I major opcodes, instr[6:0]
`define OPC_LOAD   7'b0000011
`define OPC_OP_IMM 7'b0010011
`define OPC_AUIPC  7'b0010111
`define OPC_STORE  7'b0100011
`define OPC_OP     7'b0110011
`define OPC_LUI    7'b0110111
`define OPC_BRANCH 7'b1100011
`define OPC_JALR   7'b1100111
`define OPC_JAL    7'b1101111

// funct7 values
// alt selects SUB over ADD and SRA/SRAI over SRL/SRLI
`define F7_BASE 7'b0000000
`define F7_ALT  7'b0100000

`endif

// File: verilog/decode_pkg.sv
`include "decode_params.svh"

package decode_pkg;

    typedef logic [`XLEN-1:0]      word_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

    // supported RV32I ops
    typedef enum logic [`OP_W-1:0] {
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND
    } op_e;

    // one fetched instruction with the free ROB tag
    typedef struct packed {
        word_t    instr;
        word_t    pc;
        rob_tag_t tag;
    } fetch_t;

    typedef struct packed {
        op_e      op;
        logic     to_lsb;
        logic     need_rs1;
        logic     need_rs2;
        logic     writes_rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    imm;
        word_t    pc;
    } decoded_t;

    typedef struct packed {
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic     need_rs1;
        logic     need_rs2;
    } reg_query_t;

    // register status table answer
    typedef struct packed {
        logic     rs1_renamed;
        rob_tag_t rs1_tag;
        word_t    rs1_value;
        logic     rs2_renamed;
        rob_tag_t rs2_tag;
        word_t    rs2_value;
    } reg_resp_t;

    // ROB lookup answer, indexed by the tags in reg_resp
    typedef struct packed {
        logic  rs1_ready;
        word_t rs1_value;
        logic  rs2_ready;
        word_t rs2_value;
    } rob_resp_t;

    typedef struct packed {
        word_t    value;
        logic     pending;
        rob_tag_t tag;
    } operand_t;

    // shared payload for the reservation stations and the load/store buffer
    typedef struct packed {
        op_e      op;
        operand_t rs1;
        operand_t rs2;
        word_t    imm;
        rob_tag_t dest_tag;
        word_t    pc;
    } issue_t;

    typedef struct packed {
        rob_tag_t tag;
        op_e      op;
        reg_idx_t rd;
        logic     writes_rd;
        word_t    instr;
    } rob_alloc_t;

    typedef struct packed {
        reg_idx_t rd;
        rob_tag_t tag;
    } rename_t;

endpackage

// File: verilog/instr_decoder.sv
`include "decode_params.svh"

module instr_decoder
    import decode_pkg::*;
(
    input  word_t instr,
    output op_e   op,
    output logic  to_lsb,
    output logic  need_rs1,
    output logic  need_rs2,
    output logic  writes_rd,
    output logic  legal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       rd_used;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        op       = OP_ADDI;
        to_lsb   = 1'b0;
        need_rs1 = 1'b0;
        need_rs2 = 1'b0;
        rd_used  = 1'b0;
        legal    = 1'b1;
        case (opcode)
            `OPC_LUI: begin
                op      = OP_LUI;
                rd_used = 1'b1;
            end
            `OPC_AUIPC: begin
                op      = OP_AUIPC;
                rd_used = 1'b1;
            end
            `OPC_JAL: begin
                op      = OP_JAL;
                rd_used = 1'b1;
            end
            `OPC_JALR: begin
                op       = OP_JALR;
                need_rs1 = 1'b1;
                rd_used  = 1'b1;
                legal    = (funct3 == 3'b000);
            end
            `OPC_BRANCH: begin
                need_rs1 = 1'b1;
                need_rs2 = 1'b1;
                case (funct3)
                    3'b000:  op = OP_BEQ;
                    3'b001:  op = OP_BNE;
                    3'b100:  op = OP_BLT;
                    3'b101:  op = OP_BGE;
                    3'b110:  op = OP_BLTU;
                    3'b111:  op = OP_BGEU;
                    default: legal = 1'b0;
                endcase
            end
            `OPC_LOAD: begin
                to_lsb   = 1'b1;
                need_rs1 = 1'b1;
                rd_used  = 1'b1;
                case (funct3)
                    3'b000:  op = OP_LB;
                    3'b001:  op = OP_LH;
                    3'b010:  op = OP_LW;
                    3'b100:  op = OP_LBU;
                    3'b101:  op = OP_LHU;
                    default: legal = 1'b0;
                endcase
            end
            `OPC_STORE: begin
                to_lsb   = 1'b1;
                need_rs1 = 1'b1;
                need_rs2 = 1'b1;
                case (funct3)
                    3'b000:  op = OP_SB;
                    3'b001:  op = OP_SH;
                    3'b010:  op = OP_SW;
                    default: legal = 1'b0;
                endcase
            end
            `OPC_OP_IMM: begin
                need_rs1 = 1'b1;
                rd_used  = 1'b1;
                case (funct3)
                    3'b000: op = OP_ADDI;
                    3'b010: op = OP_SLTI;
                    3'b011: op = OP_SLTIU;
                    3'b100: op = OP_XORI;
                    3'b110: op = OP_ORI;
                    3'b111: op = OP_ANDI;
                    3'b001: begin
                        op    = OP_SLLI;
                        legal = (funct7 == `F7_BASE);
                    end
                    default: begin
                        // funct3 101, shift right by shamt
                        op    = (funct7 == `F7_ALT) ? OP_SRAI : OP_SRLI;
                        legal = (funct7 == `F7_BASE) || (funct7 == `F7_ALT);
                    end
                endcase
            end
            `OPC_OP: begin
                need_rs1 = 1'b1;
                need_rs2 = 1'b1;
                rd_used  = 1'b1;
                if (funct7 == `F7_BASE) begin
                    case (funct3)
                        3'b000:  op = OP_ADD;
                        3'b001:  op = OP_SLL;
                        3'b010:  op = OP_SLT;
                        3'b011:  op = OP_SLTU;
                        3'b100:  op = OP_XOR;
                        3'b101:  op = OP_SRL;
                        3'b110:  op = OP_OR;
                        default: op = OP_AND;
                    endcase
                end else if (funct7 == `F7_ALT && funct3 == 3'b000) begin
                    op = OP_SUB;
                end else if (funct7 == `F7_ALT && funct3 == 3'b101) begin
                    op = OP_SRA;
                end else begin
                    legal = 1'b0;
                end
            end
            // FENCE, SYSTEM and anything unknown
            default: legal = 1'b0;
        endcase
    end

    // x0 is never renamed
    assign writes_rd = rd_used && (instr[11:7] != '0);

endmodule

// File: verilog/imm_gen.sv
`include "decode_params.svh"

module imm_gen
    import decode_pkg::*;
(
    input  word_t instr,
    output word_t imm
);

    always_comb begin
        case (instr[6:0])
            `OPC_LOAD, `OPC_OP_IMM, `OPC_JALR: begin
                imm = {{(`XLEN-12){instr[31]}}, instr[31:20]};
            end
            `OPC_STORE: begin
                imm = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
            end
            `OPC_BRANCH: begin
                imm = {{(`XLEN-13){instr[31]}}, instr[31], instr[7],
                       instr[30:25], instr[11:8], 1'b0};
            end
            `OPC_LUI, `OPC_AUIPC: begin
                imm = {instr[31:12], 12'b0};
            end
            `OPC_JAL: begin
                imm = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12],
                       instr[20], instr[30:21], 1'b0};
            end
            // R type and unsupported formats
            default: imm = '0;
        endcase
    end

endmodule

// File: verilog/operand_resolve.sv
module operand_resolve
    import decode_pkg::*;
(
    input  reg_idx_t index,
    input  logic     renamed,
    input  rob_tag_t reg_tag,
    input  word_t    reg_value,
    input  logic     rob_ready,
    input  word_t    rob_value,
    output operand_t operand
);

    always_comb begin
        operand.value   = '0;
        operand.pending = 1'b0;
        operand.tag     = '0;
        if (index == '0) begin
            // x0 reads as zero whatever the tables say
            operand.value = '0;
        end else if (!renamed) begin
            operand.value = reg_value;
        end else if (rob_ready) begin
            // producer finished but not yet committed
            operand.value = rob_value;
        end else begin
            operand.pending = 1'b1;
            operand.tag     = reg_tag;
        end
    end

endmodule

// File: verilog/dispatch_reg.sv
module dispatch_reg
    import decode_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     fetch_valid,
    input  logic     flush,
    input  logic     stall,
    input  logic     legal,
    input  decoded_t next,
    input  fetch_t   fetch,
    output decoded_t held,
    output fetch_t   held_fetch,
    output logic     held_valid
);

    logic capture;

    // flush or stall drops the offered instruction, no retry
    assign capture = fetch_valid && legal && !flush && !stall;

    // one-cycle strobe per captured instruction
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_valid <= 1'b0;
        end else begin
            held_valid <= capture;
        end
    end

    // payload only loads on capture and holds otherwise
    always_ff @(posedge clk) begin
        if (capture) begin
            held       <= next;
            held_fetch <= fetch;
        end
    end

endmodule

// File: verilog/decode_stage.sv
`include "decode_params.svh"

module decode_stage
    import decode_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       fetch_valid,
    input  fetch_t     fetch,
    input  logic       flush,
    input  logic       stall,
    input  reg_resp_t  reg_resp,
    input  rob_resp_t  rob_resp,
    output reg_query_t reg_query,
    output logic       rs_issue,
    output logic       lsb_issue,
    output issue_t     issue,
    output logic       rob_alloc_valid,
    output rob_alloc_t rob_alloc,
    output logic       rename_valid,
    output rename_t    rename
);

    op_e                   dec_op;
    logic                  dec_to_lsb;
    logic                  dec_need_rs1;
    logic                  dec_need_rs2;
    logic                  dec_writes_rd;
    logic                  dec_legal;
    word_t                 dec_imm;
    logic [`REG_IDX_W-1:0] rs1_idx;
    logic [`REG_IDX_W-1:0] rs2_idx;
    logic [`REG_IDX_W-1:0] rd_idx;
    decoded_t              next;
    decoded_t              held;
    fetch_t                held_fetch;
    logic                  held_valid;
    operand_t              rs1_opnd;
    operand_t              rs2_opnd;

    instr_decoder i_instr_decoder (
        .instr     (fetch.instr),
        .op        (dec_op),
        .to_lsb    (dec_to_lsb),
        .need_rs1  (dec_need_rs1),
        .need_rs2  (dec_need_rs2),
        .writes_rd (dec_writes_rd),
        .legal     (dec_legal)
    );

    imm_gen i_imm_gen (
        .instr (fetch.instr),
        .imm   (dec_imm)
    );

    // unused register fields read as x0 so they resolve to zero
    assign rs1_idx = dec_need_rs1 ? fetch.instr[19:15] : '0;
    assign rs2_idx = dec_need_rs2 ? fetch.instr[24:20] : '0;
    assign rd_idx  = dec_writes_rd ? fetch.instr[11:7] : '0;

    assign next = '{op: dec_op, to_lsb: dec_to_lsb, need_rs1: dec_need_rs1,
                    need_rs2: dec_need_rs2, writes_rd: dec_writes_rd,
                    rs1: rs1_idx, rs2: rs2_idx, rd: rd_idx,
                    imm: dec_imm, pc: fetch.pc};

    dispatch_reg i_dispatch_reg (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .flush       (flush),
        .stall       (stall),
        .legal       (dec_legal),
        .next        (next),
        .fetch       (fetch),
        .held        (held),
        .held_fetch  (held_fetch),
        .held_valid  (held_valid)
    );

    // lookups answer in the same cycle
    assign reg_query = '{rs1: held.rs1, rs2: held.rs2,
                         need_rs1: held.need_rs1, need_rs2: held.need_rs2};

    operand_resolve i_rs1_resolve (
        .index     (held.rs1),
        .renamed   (reg_resp.rs1_renamed),
        .reg_tag   (reg_resp.rs1_tag),
        .reg_value (reg_resp.rs1_value),
        .rob_ready (rob_resp.rs1_ready),
        .rob_value (rob_resp.rs1_value),
        .operand   (rs1_opnd)
    );

    operand_resolve i_rs2_resolve (
        .index     (held.rs2),
        .renamed   (reg_resp.rs2_renamed),
        .reg_tag   (reg_resp.rs2_tag),
        .reg_value (reg_resp.rs2_value),
        .rob_ready (rob_resp.rs2_ready),
        .rob_value (rob_resp.rs2_value),
        .operand   (rs2_opnd)
    );

    assign rs_issue        = held_valid && !held.to_lsb;
    assign lsb_issue       = held_valid && held.to_lsb;
    assign rob_alloc_valid = held_valid;
    assign rename_valid    = held_valid && held.writes_rd;

    assign issue = '{op: held.op, rs1: rs1_opnd, rs2: rs2_opnd, imm: held.imm,
                     dest_tag: held_fetch.tag, pc: held.pc};

    assign rob_alloc = '{tag: held_fetch.tag, op: held.op, rd: held.rd,
                         writes_rd: held.writes_rd, instr: held_fetch.instr};

    assign rename = '{rd: held.rd, tag: held_fetch.tag};

endmodule

// File: test/tb_decode_stage.sv
`include "decode_params.svh"

module tb_decode_stage
    import decode_pkg::*;
();

    localparam int N_IDLE    = 16;
    localparam int N_RS      = 300;
    localparam int N_LSB     = 200;
    localparam int N_OPERAND = 300;
    localparam int N_RENAME  = 200;
    localparam int N_DROP    = 300;
    // reset, one drain cycle per test, plus slack
    localparam int TOTAL_CYCLES = 4 + N_IDLE + N_RS + N_LSB + N_OPERAND + N_RENAME
                                  + N_DROP + 6 + 100;

    // reservation station opcodes first, then load and store
    localparam logic [6:0] OPCODES [9] = '{`OPC_OP, `OPC_OP_IMM, `OPC_LUI, `OPC_AUIPC,
                                          `OPC_BRANCH, `OPC_JAL, `OPC_JALR,
                                          `OPC_LOAD, `OPC_STORE};

    logic       clk;
    logic       rst_n;
    logic       fetch_valid;
    fetch_t     fetch;
    logic       flush;
    logic       stall;
    reg_resp_t  reg_resp;
    rob_resp_t  rob_resp;
    reg_query_t reg_query;
    logic       rs_issue;
    logic       lsb_issue;
    issue_t     issue;
    logic       rob_alloc_valid;
    rob_alloc_t rob_alloc;
    logic       rename_valid;
    rename_t    rename;

    logic [15:0] lfsr = 16'd8866;
    int          check_count = 0;
    int          error_count = 0;

    // offer from the previous cycle, checked one cycle later
    logic     prev_valid = 1'b0;
    decoded_t prev_dec;
    fetch_t   prev_fetch;

    decode_stage i_decode_stage (
        .clk             (clk),
        .rst_n           (rst_n),
        .fetch_valid     (fetch_valid),
        .fetch           (fetch),
        .flush           (flush),
        .stall           (stall),
        .reg_resp        (reg_resp),
        .rob_resp        (rob_resp),
        .reg_query       (reg_query),
        .rs_issue        (rs_issue),
        .lsb_issue       (lsb_issue),
        .issue           (issue),
        .rob_alloc_valid (rob_alloc_valid),
        .rob_alloc       (rob_alloc),
        .rename_valid    (rename_valid),
        .rename          (rename)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic word_t sext(input word_t v, input int bits);
        return word_t'($signed(v << (32 - bits)) >>> (32 - bits));
    endfunction

    // reference decode, key is {opcode, funct3, funct7}
    function automatic void model_decode(input fetch_t f, output decoded_t d,
                                         output logic legal);
        logic [6:0]  opc;
        logic [16:0] key;
        logic        rd_used;
        opc = f.instr[6:0];
        key = {opc, f.instr[14:12], f.instr[31:25]};
        d = '0;
        legal = 1'b1;
        casez (key)
            17'b0110111_???_???????: d.op = OP_LUI;
            17'b0010111_???_???????: d.op = OP_AUIPC;
            17'b1101111_???_???????: d.op = OP_JAL;
            17'b1100111_000_???????: d.op = OP_JALR;
            17'b1100011_000_???????: d.op = OP_BEQ;
            17'b1100011_001_???????: d.op = OP_BNE;
            17'b1100011_100_???????: d.op = OP_BLT;
            17'b1100011_101_???????: d.op = OP_BGE;
            17'b1100011_110_???????: d.op = OP_BLTU;
            17'b1100011_111_???????: d.op = OP_BGEU;
            17'b0000011_000_???????: d.op = OP_LB;
            17'b0000011_001_???????: d.op = OP_LH;
            17'b0000011_010_???????: d.op = OP_LW;
            17'b0000011_100_???????: d.op = OP_LBU;
            17'b0000011_101_???????: d.op = OP_LHU;
            17'b0100011_000_???????: d.op = OP_SB;
            17'b0100011_001_???????: d.op = OP_SH;
            17'b0100011_010_???????: d.op = OP_SW;
            17'b0010011_000_???????: d.op = OP_ADDI;
            17'b0010011_010_???????: d.op = OP_SLTI;
            17'b0010011_011_???????: d.op = OP_SLTIU;
            17'b0010011_100_???????: d.op = OP_XORI;
            17'b0010011_110_???????: d.op = OP_ORI;
            17'b0010011_111_???????: d.op = OP_ANDI;
            17'b0010011_001_0000000: d.op = OP_SLLI;
            17'b0010011_101_0000000: d.op = OP_SRLI;
            17'b0010011_101_0100000: d.op = OP_SRAI;
            17'b0110011_000_0000000: d.op = OP_ADD;
            17'b0110011_000_0100000: d.op = OP_SUB;
            17'b0110011_001_0000000: d.op = OP_SLL;
            17'b0110011_010_0000000: d.op = OP_SLT;
            17'b0110011_011_0000000: d.op = OP_SLTU;
            17'b0110011_100_0000000: d.op = OP_XOR;
            17'b0110011_101_0000000: d.op = OP_SRL;
            17'b0110011_101_0100000: d.op = OP_SRA;
            17'b0110011_110_0000000: d.op = OP_OR;
            17'b0110011_111_0000000: d.op = OP_AND;
            default: legal = 1'b0;
        endcase
        d.to_lsb    = (opc == `OPC_LOAD) || (opc == `OPC_STORE);
        d.need_rs1  = !(opc inside {`OPC_LUI, `OPC_AUIPC, `OPC_JAL});
        d.need_rs2  = opc inside {`OPC_BRANCH, `OPC_STORE, `OPC_OP};
        rd_used     = !(opc inside {`OPC_BRANCH, `OPC_STORE});
        d.writes_rd = rd_used && (f.instr[11:7] != 5'd0);
        d.rs1       = d.need_rs1 ? f.instr[19:15] : '0;
        d.rs2       = d.need_rs2 ? f.instr[24:20] : '0;
        d.rd        = d.writes_rd ? f.instr[11:7] : '0;
        case (opc)
            `OPC_LUI, `OPC_AUIPC: d.imm = {f.instr[31:12], 12'h000};
            `OPC_LOAD, `OPC_OP_IMM, `OPC_JALR: d.imm = sext(f.instr[31:20], 12);
            `OPC_STORE: d.imm = sext({f.instr[31:25], f.instr[11:7]}, 12);
            `OPC_BRANCH: begin
                d.imm = sext({f.instr[31], f.instr[7], f.instr[30:25], f.instr[11:8], 1'b0}, 13);
            end
            `OPC_JAL: begin
                d.imm = sext({f.instr[31], f.instr[19:12], f.instr[20], f.instr[30:21], 1'b0},
                             21);
            end
            default: d.imm = '0;
        endcase
        d.pc = f.pc;
    endfunction

    // mix 0 rs ops, 1 load/store, 2 any legal, 3 anything
    function automatic fetch_t make_fetch(input int mix, input int zero_bias);
        fetch_t   f;
        decoded_t d;
        logic     legal;
        int       idx;
        do begin
            f.instr = rand_bits(32);
            f.pc    = rand_bits(30) << 2;
            f.tag   = rob_tag_t'(rand_bits(`ROB_TAG_W));
            case (mix)
                0: f.instr[6:0] = OPCODES[rand_bits(3) % 7];
                1: f.instr[6:0] = OPCODES[7 + int'(rand_bits(1))];
                2: f.instr[6:0] = OPCODES[rand_bits(4) % 9];
                default: begin
                    idx = int'(rand_bits(4));
                    if (idx < 9) begin
                        f.instr[6:0] = OPCODES[idx];
                    end else if (idx == 9) begin
                        f.instr[6:0] = 7'b0001111;
                    end else if (idx == 10) begin
                        f.instr[6:0] = 7'b1110011;
                    end
                end
            endcase
            // steer funct7 toward the values that matter for shifts and SUB
            if (f.instr[6:0] == `OPC_OP || f.instr[6:0] == `OPC_OP_IMM) begin
                idx = int'(rand_bits(2));
                if (idx < 2) begin
                    f.instr[31:25] = `F7_BASE;
                end else if (idx == 2) begin
                    f.instr[31:25] = `F7_ALT;
                end
            end
            if (rand_bits(4) < zero_bias) f.instr[11:7] = '0;
            if (rand_bits(4) < zero_bias) f.instr[19:15] = '0;
            if (rand_bits(4) < zero_bias) f.instr[24:20] = '0;
            model_decode(f, d, legal);
        end while (mix != 3 && !legal);
        return f;
    endfunction

    function automatic void make_responses(output reg_resp_t rr, output rob_resp_t br);
        rr.rs1_renamed = rand_bits(1) != 0;
        rr.rs1_tag     = rob_tag_t'(rand_bits(`ROB_TAG_W));
        rr.rs1_value   = rand_bits(32);
        rr.rs2_renamed = rand_bits(1) != 0;
        rr.rs2_tag     = rob_tag_t'(rand_bits(`ROB_TAG_W));
        rr.rs2_value   = rand_bits(32);
        br.rs1_ready   = rand_bits(1) != 0;
        br.rs1_value   = rand_bits(32);
        br.rs2_ready   = rand_bits(1) != 0;
        br.rs2_value   = rand_bits(32);
    endfunction

    function automatic operand_t expect_operand(input reg_idx_t idx, input logic renamed,
                                                input rob_tag_t tag, input word_t reg_value,
                                                input logic ready, input word_t rob_value);
        if (idx == '0) return '{value: '0, pending: 1'b0, tag: '0};
        if (!renamed) return '{value: reg_value, pending: 1'b0, tag: '0};
        if (ready) return '{value: rob_value, pending: 1'b0, tag: '0};
        return '{value: '0, pending: 1'b1, tag: tag};
    endfunction

    task automatic check_val(input string name, input logic [159:0] got,
                             input logic [159:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_outputs(input reg_resp_t rr, input rob_resp_t br);
        issue_t     ei;
        rob_alloc_t ea;
        reg_query_t eq;
        rename_t    en;
        check_val("rs_issue", rs_issue, prev_valid && !prev_dec.to_lsb);
        check_val("lsb_issue", lsb_issue, prev_valid && prev_dec.to_lsb);
        check_val("rob_alloc_valid", rob_alloc_valid, prev_valid);
        check_val("rename_valid", rename_valid, prev_valid && prev_dec.writes_rd);
        if (prev_valid) begin
            ei.op       = prev_dec.op;
            ei.rs1      = expect_operand(prev_dec.rs1, rr.rs1_renamed, rr.rs1_tag,
                                         rr.rs1_value, br.rs1_ready, br.rs1_value);
            ei.rs2      = expect_operand(prev_dec.rs2, rr.rs2_renamed, rr.rs2_tag,
                                         rr.rs2_value, br.rs2_ready, br.rs2_value);
            ei.imm      = prev_dec.imm;
            ei.dest_tag = prev_fetch.tag;
            ei.pc       = prev_fetch.pc;
            eq = '{rs1: prev_dec.rs1, rs2: prev_dec.rs2,
                   need_rs1: prev_dec.need_rs1, need_rs2: prev_dec.need_rs2};
            ea = '{tag: prev_fetch.tag, op: prev_dec.op, rd: prev_dec.rd,
                   writes_rd: prev_dec.writes_rd, instr: prev_fetch.instr};
            en = '{rd: prev_dec.rd, tag: prev_fetch.tag};
            check_val("issue", issue, ei);
            check_val("reg_query", reg_query, eq);
            check_val("rob_alloc", rob_alloc, ea);
            if (prev_dec.writes_rd) check_val("rename", rename, en);
        end
    endtask

    // rates are out of 16
    task automatic run_test(input string name, input int cycles, input int mix,
                            input int zero_bias, input int offer_rate, input int drop_rate);
        fetch_t    f;
        decoded_t  d;
        logic      legal;
        logic      fv;
        logic      fl;
        logic      st;
        reg_resp_t rr;
        rob_resp_t br;
        int        checks0;
        int        errors0;
        checks0 = check_count;
        errors0 = error_count;
        for (int i = 0; i <= cycles; i++) begin
            // last pass offers nothing and only drains
            fv = (i < cycles) && (rand_bits(4) < offer_rate);
            fl = rand_bits(4) < drop_rate;
            st = rand_bits(4) < drop_rate;
            f  = make_fetch(mix, zero_bias);
            model_decode(f, d, legal);
            make_responses(rr, br);
            @(posedge clk);
            fetch_valid <= fv;
            fetch       <= f;
            flush       <= fl;
            stall       <= st;
            reg_resp    <= rr;
            rob_resp    <= br;
            @(negedge clk);
            check_outputs(rr, br);
            prev_valid = fv && legal && !fl && !st;
            prev_dec   = d;
            prev_fetch = f;
        end
        $display("test %s: %0d checks, %0d errors", name, check_count - checks0,
                 error_count - errors0);
    endtask

    initial begin
        #(4 * TOTAL_CYCLES);
        $display("watchdog expired after %0d cycles, the run did not finish", TOTAL_CYCLES);
        $display("Regression failed");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        fetch_valid = 1'b0;
        fetch       = '0;
        flush       = 1'b0;
        stall       = 1'b0;
        reg_resp    = '0;
        rob_resp    = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        run_test("idle_after_reset", N_IDLE, 3, 0, 0, 0);
        run_test("rs_ops", N_RS, 0, 2, 16, 0);
        run_test("lsb_ops", N_LSB, 1, 2, 12, 0);
        run_test("operands", N_OPERAND, 2, 6, 16, 0);
        run_test("alloc_rename", N_RENAME, 2, 8, 14, 0);
        run_test("flush_stall_illegal", N_DROP, 3, 2, 12, 4);

        $display("total: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+include
verilog/decode_pkg.sv
verilog/instr_decoder.sv
verilog/imm_gen.sv
verilog/operand_resolve.sv
verilog/dispatch_reg.sv
verilog/decode_stage.sv
test/tb_decode_stage.sv

// File: Makefile
TOP := tb_decode_stage

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f sources.f -Mdir obj_dir

# pass only when the pass line shows up in the simulator output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir
